// ==== miss_checker.sv ====
`timescale 1ns/10ps
`include "miss_defs.svh"

module miss_checker
    import miss_pkg::*;
(
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   req_valid,
    input  logic [`PADDR_BITS-1:0] req_paddr,
    input  logic [`SLOT_BITS-1:0]  req_slot,
    input  logic                   req_is_store,
    input  logic                   fill_valid,
    input  line_addr_t             fill_line_addr,
    input  logic                   mem_busy,
    input  logic                   retry,
    input  logic                   wakeup_valid,
    input  wakeup_t                wakeup,
    input  logic                   stray_fill,
    input  logic                   mem_req,
    input  line_addr_t             mem_line_addr,
    input  logic                   mshr_full,
    output int                     value_errors,
    output int                     pulse_errors
);

    localparam int N     = `MSHR_ENTRIES;
    localparam int DEPTH = `ISSUE_DEPTH;

    typedef struct packed {
        logic       retry;
        logic       wakeup_valid;
        wakeup_t    wakeup;
        logic       stray_fill;
        logic       mem_req;
        line_addr_t mem_line_addr;
        logic       mshr_full;
    } expect_t;

    logic [N-1:0] m_valid;
    line_addr_t   m_line [N];
    wakeup_t      m_mask [N];
    line_addr_t   issue_q [$];
    expect_t      want;
    int           n_value = 0;
    int           n_pulse = 0;

    assign value_errors = n_value;
    assign pulse_errors = n_pulse;

    // one clock edge of the MSHR unit, applied to the model state
    function automatic expect_t model_step(input logic rv, input line_addr_t rl,
                                           input slot_mask_t rs, input logic st,
                                           input logic fv, input line_addr_t fl,
                                           input logic busy);
        expect_t e;
        int      i;
        int      hit;
        int      fhit;
        int      free_idx;
        logic    do_merge;
        logic    do_alloc;
        wakeup_t bit_m;
        e        = '0;
        hit      = -1;
        fhit     = -1;
        free_idx = -1;
        for (i = 0; i < N; i++) begin
            if (m_valid[i] && m_line[i] == rl) hit = i;
            if (fv && m_valid[i] && m_line[i] == fl) fhit = i;
            if (!m_valid[i] && free_idx < 0) free_idx = i;
        end
        bit_m.rd_slots = st ? '0 : rs;
        bit_m.sw_slots = st ? rs : '0;
        do_merge = rv && (hit >= 0);
        // a fill in the same cycle frees nothing for this request
        do_alloc = rv && (hit < 0) && (free_idx >= 0) && (issue_q.size() < DEPTH);
        e.retry  = rv && !do_merge && !do_alloc;
        if (fhit >= 0) begin
            e.wakeup_valid = 1'b1;
            e.wakeup       = m_mask[fhit];
            if (do_merge && hit == fhit) e.wakeup = e.wakeup | bit_m;  // folded request
            m_valid[fhit] = 1'b0;
        end
        e.stray_fill = fv && (fhit < 0);
        if (!busy && issue_q.size() != 0) begin
            e.mem_req       = 1'b1;
            e.mem_line_addr = issue_q.pop_front();
        end
        if (do_merge && hit != fhit) m_mask[hit] = m_mask[hit] | bit_m;
        if (do_alloc) begin
            issue_q.push_back(rl);
            m_valid[free_idx] = 1'b1;
            m_line[free_idx]  = rl;
            m_mask[free_idx]  = bit_m;
        end
        e.mshr_full = &m_valid;
        return e;
    endfunction

    task automatic check_pulse(input string name, input logic exp_v, input logic got_v);
        if (got_v !== exp_v) begin
            n_pulse++;
            if (exp_v) $display("%0t: expected a %s pulse but none came", $time, name);
            else $display("%0t: %s pulsed when it should have stayed low", $time, name);
        end
    endtask

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            m_valid = '0;
            issue_q.delete();
            want = '0;
        end else begin
            want = model_step(req_valid, req_paddr[`PADDR_BITS-1 -: `LINE_ADDR_BITS],
                              req_slot, req_is_store, fill_valid, fill_line_addr, mem_busy);
        end
    end

    // outputs are registered on the rising edge, so they are settled here
    always @(negedge clk) begin
        check_pulse("retry", want.retry, retry);
        check_pulse("wakeup_valid", want.wakeup_valid, wakeup_valid);
        check_pulse("stray_fill", want.stray_fill, stray_fill);
        check_pulse("mem_req", want.mem_req, mem_req);
        if (want.wakeup_valid && wakeup_valid && wakeup !== want.wakeup) begin
            n_value++;
            $display("CHECK FAILED wakeup: expected %h, got %h", want.wakeup, wakeup);
        end
        if (want.mem_req && mem_req && mem_line_addr !== want.mem_line_addr) begin
            n_value++;
            $display("CHECK FAILED mem_line_addr: expected %h, got %h",
                     want.mem_line_addr, mem_line_addr);
        end
        if (mshr_full !== want.mshr_full) begin
            n_value++;
            $display("CHECK FAILED mshr_full: expected %h, got %h", want.mshr_full, mshr_full);
        end
    end

endmodule

// ==== miss_ctrl.sv ====
`timescale 1ns/10ps

module miss_ctrl
    import miss_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  miss_req_t req,
    input  logic      req_valid,
    input  logic      fill_valid,
    input  logic      req_hit,
    input  logic      fill_hit,
    input  logic      collide,
    input  logic      full,
    input  logic      fifo_full,
    input  wakeup_t   fill_masks,
    output logic      alloc,
    output logic      merge,
    output logic      retry,
    output logic      wakeup_valid,
    output wakeup_t   wakeup,
    output logic      stray_fill
);

    logic    fold;
    wakeup_t fold_masks;
    wakeup_t wakeup_d;

    assign merge = req_valid && req_hit;
    // the entry freed by a fill this cycle is not offered to the request
    assign alloc = req_valid && !req_hit && !full && !fifo_full;
    assign fold  = req_valid && collide;  // request names the line being filled

    always_comb begin
        fold_masks = '0;
        if (fold) begin
            if (req.is_store) begin
                fold_masks.sw_slots = req.slot;
            end else begin
                fold_masks.rd_slots = req.slot;
            end
        end
    end

    assign wakeup_d = (fill_valid && fill_hit) ? (fill_masks | fold_masks) : '0;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            retry        <= 1'b0;
            wakeup_valid <= 1'b0;
            wakeup       <= '0;
            stray_fill   <= 1'b0;
        end else begin
            retry        <= req_valid && !alloc && !merge;
            wakeup_valid <= fill_valid && fill_hit;
            wakeup       <= wakeup_d;  // stays zero outside the wakeup cycle
            stray_fill   <= fill_valid && !fill_hit;
        end
    end

    a_req_slot_onehot: assert property (
        @(posedge clk) disable iff (!arst_n)
        req_valid |-> $onehot(req.slot)
    ) else $error("miss report without exactly one slot bit");

    // every entry starts with the slot of its primary miss
    a_wakeup_not_empty: assert property (
        @(posedge clk) disable iff (!arst_n)
        wakeup_valid |-> (wakeup != '0)
    ) else $error("wakeup pulse carries no waiting slot");

endmodule

// ==== miss_defs.svh ====
`ifndef MISS_DEFS_SVH
`define MISS_DEFS_SVH

// outstanding line misses held at once
`define MSHR_ENTRIES   8

// one bit per load or store queue entry
`define SLOT_BITS      8

// physical request address and its line part
`define PADDR_BITS     15
`define LINE_ADDR_BITS 11

// primary-miss line addresses waiting for memory
`define ISSUE_DEPTH    4

`endif

// ==== miss_issue_fifo.sv ====
`timescale 1ns/10ps
`include "miss_defs.svh"

module miss_issue_fifo
    import miss_pkg::*;
#(
    parameter int DEPTH = `ISSUE_DEPTH
) (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       push,
    input  line_addr_t push_line_addr,
    input  logic       mem_busy,
    output logic       fifo_full,
    output logic       mem_req,
    output line_addr_t mem_line_addr
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    line_addr_t       buf_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             pop;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign fifo_full = (count == CNT_W'(DEPTH));
    assign pop       = !mem_busy && (count != '0);  // one address per free cycle

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            mem_req       <= 1'b0;
            mem_line_addr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr        <= ptr_inc(rd_ptr);
                mem_line_addr <= buf_q[rd_ptr];
            end
            mem_req <= pop;
            count   <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            buf_q[wr_ptr] <= push_line_addr;
        end
    end

    // the control side turns primary misses into retries while the queue is full
    a_no_push_full: assert property (
        @(posedge clk) disable iff (!arst_n)
        push |-> !fifo_full
    ) else $error("issue queue pushed while full");

endmodule

// ==== miss_pkg.sv ====
`include "miss_defs.svh"

package miss_pkg;

    // a line address as it is held in an entry and sent to memory
    typedef logic [`LINE_ADDR_BITS-1:0] line_addr_t;

    typedef logic [`SLOT_BITS-1:0] slot_mask_t;

    typedef struct packed {
        line_addr_t line_addr;
        slot_mask_t slot;      // one-hot queue entry
        logic       is_store;  // set when the store queue reported the miss
    } miss_req_t;

    typedef struct packed {
        logic       valid;
        line_addr_t line_addr;
        slot_mask_t rd_slots;  // load slots waiting on the line
        slot_mask_t sw_slots;  // store slots waiting on the line
    } mshr_entry_t;

    // both masks of a released entry leave in one pulse
    typedef struct packed {
        slot_mask_t rd_slots;
        slot_mask_t sw_slots;
    } wakeup_t;

endpackage

// ==== miss_unit.f ====
+incdir+.
miss_pkg.sv
miss_ctrl.sv
mshr_file.sv
miss_issue_fifo.sv
miss_unit.sv
miss_checker.sv
tb_miss_unit.sv

// ==== miss_unit.sv ====
`timescale 1ns/10ps
`include "miss_defs.svh"

module miss_unit
    import miss_pkg::*;
(
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   req_valid,
    input  logic [`PADDR_BITS-1:0] req_paddr,
    input  logic [`SLOT_BITS-1:0]  req_slot,
    input  logic                   req_is_store,
    input  logic                   fill_valid,
    input  line_addr_t             fill_line_addr,
    input  logic                   mem_busy,
    output logic                   retry,
    output logic                   wakeup_valid,
    output wakeup_t                wakeup,
    output logic                   stray_fill,
    output logic                   mem_req,
    output line_addr_t             mem_line_addr,
    output logic                   mshr_full
);

    miss_req_t req;
    logic      req_hit;
    logic      fill_hit;
    logic      collide;
    logic      fifo_full;
    logic      alloc;
    logic      merge;
    wakeup_t   fill_masks;

    assign req.line_addr = req_paddr[`PADDR_BITS-1 -: `LINE_ADDR_BITS];  // low bits pick a byte
    assign req.slot      = req_slot;
    assign req.is_store  = req_is_store;

    miss_ctrl i_miss_ctrl (
        .clk          (clk),
        .arst_n       (arst_n),
        .req          (req),
        .req_valid    (req_valid),
        .fill_valid   (fill_valid),
        .req_hit      (req_hit),
        .fill_hit     (fill_hit),
        .collide      (collide),
        .full         (mshr_full),
        .fifo_full    (fifo_full),
        .fill_masks   (fill_masks),
        .alloc        (alloc),
        .merge        (merge),
        .retry        (retry),
        .wakeup_valid (wakeup_valid),
        .wakeup       (wakeup),
        .stray_fill   (stray_fill)
    );

    mshr_file i_mshr_file (
        .clk            (clk),
        .arst_n         (arst_n),
        .req            (req),
        .merge          (merge),
        .alloc          (alloc),
        .fill_valid     (fill_valid),
        .fill_line_addr (fill_line_addr),
        .req_hit        (req_hit),
        .fill_hit       (fill_hit),
        .collide        (collide),
        .full           (mshr_full),
        .fill_masks     (fill_masks)
    );

    miss_issue_fifo #(
        .DEPTH (`ISSUE_DEPTH)
    ) i_miss_issue_fifo (
        .clk            (clk),
        .arst_n         (arst_n),
        .push           (alloc),
        .push_line_addr (req.line_addr),
        .mem_busy       (mem_busy),
        .fifo_full      (fifo_full),
        .mem_req        (mem_req),
        .mem_line_addr  (mem_line_addr)
    );

endmodule

// ==== mshr_file.sv ====
`timescale 1ns/10ps
`include "miss_defs.svh"

module mshr_file
    import miss_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  miss_req_t  req,
    input  logic       merge,
    input  logic       alloc,
    input  logic       fill_valid,
    input  line_addr_t fill_line_addr,
    output logic       req_hit,
    output logic       fill_hit,
    output logic       collide,
    output logic       full,
    output wakeup_t    fill_masks
);

    localparam int N = `MSHR_ENTRIES;

    logic [N-1:0] valid_q;
    line_addr_t   line_q [N];
    wakeup_t      mask_q [N];
    mshr_entry_t  entry  [N];
    logic [N-1:0] req_match;
    logic [N-1:0] fill_match;
    logic [N-1:0] free_sel;
    wakeup_t      req_bit;

    // whole-entry view of the split storage
    always_comb begin
        for (int i = 0; i < N; i++) begin
            entry[i].valid     = valid_q[i];
            entry[i].line_addr = line_q[i];
            entry[i].rd_slots  = mask_q[i].rd_slots;
            entry[i].sw_slots  = mask_q[i].sw_slots;
        end
    end

    always_comb begin
        for (int i = 0; i < N; i++) begin
            req_match[i]  = entry[i].valid && (entry[i].line_addr == req.line_addr);
            fill_match[i] = fill_valid && entry[i].valid &&
                            (entry[i].line_addr == fill_line_addr);
        end
    end

    assign req_hit  = |req_match;
    assign fill_hit = |fill_match;
    assign collide  = |(req_match & fill_match);  // req_valid is applied by the control side
    assign full     = &valid_q;

    always_comb begin
        fill_masks = '0;
        for (int i = 0; i < N; i++) begin
            if (fill_match[i]) begin
                fill_masks.rd_slots = fill_masks.rd_slots | entry[i].rd_slots;
                fill_masks.sw_slots = fill_masks.sw_slots | entry[i].sw_slots;
            end
        end
    end

    // the lowest free entry wins, so the scan runs from the top down
    always_comb begin
        free_sel = '0;
        for (int i = N - 1; i >= 0; i--) begin
            if (!valid_q[i]) begin
                free_sel    = '0;
                free_sel[i] = 1'b1;
            end
        end
    end

    assign req_bit.rd_slots = req.is_store ? '0 : req.slot;
    assign req_bit.sw_slots = req.is_store ? req.slot : '0;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
        end else begin
            for (int i = 0; i < N; i++) begin
                if (alloc && free_sel[i]) begin
                    valid_q[i] <= 1'b1;
                end else if (fill_match[i]) begin
                    valid_q[i] <= 1'b0;  // masks leave through fill_masks this cycle
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < N; i++) begin
            if (alloc && free_sel[i]) begin
                line_q[i] <= req.line_addr;
                mask_q[i] <= req_bit;
            end else if (merge && req_match[i]) begin
                mask_q[i] <= mask_q[i] | req_bit;
            end
        end
    end

    // a line is only ever allocated when no entry holds it
    a_unique_req_line: assert property (
        @(posedge clk) disable iff (!arst_n)
        $onehot0(req_match)
    ) else $error("request line matches more than one MSHR entry");

    a_unique_fill_line: assert property (
        @(posedge clk) disable iff (!arst_n)
        $onehot0(fill_match)
    ) else $error("fill line matches more than one MSHR entry");

endmodule

// ==== tb_miss_unit.sv ====
`timescale 1ns/10ps
`include "miss_defs.svh"

module tb_miss_unit
    import miss_pkg::*;
;

    localparam int RESET_CYCLES    = 16;
    localparam int DIRECTED_CYCLES = 100;
    localparam int RANDOM_CYCLES   = 400;
    localparam int TIMEOUT_CYCLES  = 2 * (RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES) + 50;
    localparam int OFF_BITS        = `PADDR_BITS - `LINE_ADDR_BITS;

    logic                   clk;
    logic                   arst_n;
    logic                   req_valid;
    logic [`PADDR_BITS-1:0] req_paddr;
    logic [`SLOT_BITS-1:0]  req_slot;
    logic                   req_is_store;
    logic                   fill_valid;
    line_addr_t             fill_line_addr;
    logic                   mem_busy;
    logic                   retry;
    logic                   wakeup_valid;
    wakeup_t                wakeup;
    logic                   stray_fill;
    logic                   mem_req;
    line_addr_t             mem_line_addr;
    logic                   mshr_full;
    int                     value_errors;
    int                     pulse_errors;
    int                     cycle_count;
    logic [31:0]            lcg_state;
    logic                   hold_busy;

    miss_unit i_miss_unit (
        .clk (clk), .arst_n (arst_n),
        .req_valid (req_valid), .req_paddr (req_paddr),
        .req_slot (req_slot), .req_is_store (req_is_store),
        .fill_valid (fill_valid), .fill_line_addr (fill_line_addr),
        .mem_busy (mem_busy), .retry (retry),
        .wakeup_valid (wakeup_valid), .wakeup (wakeup),
        .stray_fill (stray_fill), .mem_req (mem_req),
        .mem_line_addr (mem_line_addr), .mshr_full (mshr_full)
    );

    miss_checker i_miss_checker (
        .clk (clk), .arst_n (arst_n),
        .req_valid (req_valid), .req_paddr (req_paddr),
        .req_slot (req_slot), .req_is_store (req_is_store),
        .fill_valid (fill_valid), .fill_line_addr (fill_line_addr),
        .mem_busy (mem_busy), .retry (retry),
        .wakeup_valid (wakeup_valid), .wakeup (wakeup),
        .stray_fill (stray_fill), .mem_req (mem_req),
        .mem_line_addr (mem_line_addr), .mshr_full (mshr_full),
        .value_errors (value_errors), .pulse_errors (pulse_errors)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] draw_random();
        lcg_state = lcg_next(lcg_state);
        return lcg_state;
    endfunction

    task automatic drive_cycle(input logic rv, input line_addr_t line, input int slot_idx,
                               input logic st, input logic fv, input line_addr_t fline,
                               input logic busy);
        logic [31:0] r;
        @(negedge clk);
        r              = draw_random();
        req_valid      = rv;
        req_paddr      = {line, r[31 -: OFF_BITS]};  // byte offset is don't-care
        req_slot       = rv ? (slot_mask_t'(1) << slot_idx) : '0;
        req_is_store   = rv && st;
        fill_valid     = fv;
        fill_line_addr = fline;
        mem_busy       = busy;
    endtask

    task automatic miss(input line_addr_t line, input int slot_idx, input logic st);
        drive_cycle(1'b1, line, slot_idx, st, 1'b0, '0, hold_busy);
    endtask

    task automatic fill(input line_addr_t line);
        drive_cycle(1'b0, '0, 0, 1'b0, 1'b1, line, hold_busy);
    endtask

    task automatic idle(input int n);
        repeat (n) drive_cycle(1'b0, '0, 0, 1'b0, 1'b0, '0, hold_busy);
    endtask

    task automatic random_traffic(input int n);
        logic [31:0] r;
        repeat (n) begin
            r = draw_random();
            // ten lines in the pool keep merges and collisions frequent
            drive_cycle(r[31], line_addr_t'(11'h0a0 + r[27:24] % 10), int'(r[23:21]), r[20],
                        r[19], line_addr_t'(11'h0a0 + r[16:13] % 10), r[12] & r[11]);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        lcg_state = 32'h0460_0c01;
        hold_busy = 1'b0;
        arst_n = 1'b0;
        req_valid = 1'b0;
        req_paddr = '0;
        req_slot = '0;
        req_is_store = 1'b0;
        fill_valid = 1'b0;
        fill_line_addr = '0;
        mem_busy = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        idle(2);
        miss(11'h010, 0, 1'b0);  // primary misses leave in allocation order
        idle(1);
        miss(11'h020, 1, 1'b1);
        miss(11'h030, 2, 1'b0);
        miss(11'h040, 3, 1'b0);
        idle(3);
        fill(11'h010);
        fill(11'h020);
        fill(11'h030);
        fill(11'h040);
        idle(2);
        for (int i = 0; i < 6; i++) miss(11'h155, i, i[0]);  // load and store merges
        idle(2);
        fill(11'h155);
        idle(2);
        for (int i = 0; i < 8; i++) miss(line_addr_t'(11'h200 + i), i, i[0]);
        idle(2);
        miss(11'h2ff, 0, 1'b0);  // new line while full retries
        miss(11'h203, 5, 1'b1);  // held line still merges
        idle(1);
        for (int i = 0; i < 8; i++) fill(line_addr_t'(11'h200 + i));
        idle(2);
        hold_busy = 1'b1;
        for (int i = 0; i < 5; i++) miss(line_addr_t'(11'h300 + i), i, 1'b0);
        idle(2);
        hold_busy = 1'b0;
        idle(6);
        for (int i = 0; i < 5; i++) fill(line_addr_t'(11'h300 + i));
        idle(2);
        miss(11'h3aa, 4, 1'b0);
        idle(2);
        drive_cycle(1'b1, 11'h3aa, 6, 1'b1, 1'b1, 11'h3aa, 1'b0);  // request meets its fill
        idle(1);
        fill(11'h3aa);
        miss(11'h3aa, 7, 1'b0);
        idle(2);
        fill(11'h3aa);
        idle(2);
        fill(11'h7ff);
        idle(2);
        random_traffic(RANDOM_CYCLES);
        hold_busy = 1'b0;
        idle(8);
        @(posedge clk);
        $display("checks done: %0d value errors, %0d pulse errors", value_errors, pulse_errors);
        if (value_errors == 0 && pulse_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
